// File: filelist.f
+incdir+test
src/jbus_pkg.sv
src/bus_cycle_ctrl.sv
src/jbus_lanes.sv
src/jbus_top.sv
test/tb_jbus.sv

// File: src/bus_cycle_ctrl.sv
// Bus cycle sequencer that splits a local request into strobe/ack phases and drives jbus_lanes, used in jbus_top
module bus_cycle_ctrl (
	input  logic                 sys_clk,
	input  logic                 rst,
	input  logic                 req,
	input  logic                 we,
	input  jbus_pkg::xfer_size_e size,
	input  logic [1:0]           addr_lo,
	input  logic                 dsp16,
	input  logic                 bigend,
	input  logic                 ext_ack,
	output logic                 busy,
	output logic                 done,
	output logic                 ext_strobe,
	output logic                 ext_we,
	output logic                 ad_load,
	output logic                 seta1,
	output logic [1:0]           dinlatch,
	output logic [1:0]           dmuxu,
	output logic [1:0]           dmuxd,
	output logic                 xdsrc
);
	import jbus_pkg::*;

	cyc_state_e state;

	// Request held for the whole transfer
	logic we_q;
	xfer_size_e size_q;
	logic [1:0] a_lo_q;
	// Long on a 16-bit bus, runs as two phases
	logic two_ph_q;

	logic accept;
	logic split;
	logic phase_ack;
	logic rd;

	// A request is taken in idle or on the done cycle
	assign busy = (state == ST_HI) || (state == ST_LO);
	assign done = (state == ST_DONE);
	assign accept = req && !busy;

	// Phase count from size and bus width
	assign split = (size == SZ_LONG) && dsp16;

	// Ack only counts while the strobe is up
	assign phase_ack = ext_strobe && ext_ack;

	// Address latched on the accepted request, valid when the strobe rises
	assign ad_load = accept;

	// Second phase of a split long addresses the lower half
	assign seta1 = (state == ST_LO) && two_ph_q;

	assign ext_we = ext_strobe && we_q;
	assign rd = !we_q;

	// Lanes take ext_din on reads
	assign xdsrc = rd;

	// Phase sequencer
	// Strobe drops the cycle after ack and stays low one cycle between phases
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ext_strobe <= 1'b0;
			we_q <= 1'b0;
			size_q <= SZ_BYTE;
			a_lo_q <= 2'b00;
			two_ph_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE, ST_DONE: begin
					if (accept) begin
						state <= split ? ST_HI : ST_LO;
						ext_strobe <= 1'b1;
						we_q <= we;
						size_q <= size;
						a_lo_q <= addr_lo;
						two_ph_q <= split;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_HI: begin
					if (phase_ack) begin
						ext_strobe <= 1'b0;
					end else if (!ext_strobe) begin
						// Gap cycle over, start the lower half
						state <= ST_LO;
						ext_strobe <= 1'b1;
					end
				end
				ST_LO: begin
					if (phase_ack) begin
						ext_strobe <= 1'b0;
					end else if (!ext_strobe) begin
						state <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Read latch enables, one cycle on the ack of a read phase
	// Upper half first on a split long, lower half second
	always_comb begin
		dinlatch = 2'b00;
		if (phase_ack && rd) begin
			if (state == ST_HI) begin
				dinlatch = 2'b10;
			end else if (two_ph_q) begin
				dinlatch = 2'b01;
			end else begin
				dinlatch = 2'b11;
			end
		end
	end

	// Lane selects
	// Steering applies to reads only, except the upper half of a split long write
	always_comb begin
		dmuxd = SEL_LO_HALF;
		dmuxu = LANE_PASS;
		case (size_q)
			SZ_BYTE: begin
				dmuxu = LANE_BYTE;
				if (rd) begin
					// 16-bit bus: byte within the half, 32-bit bus: lane 3-L when big-endian
					dmuxd = dsp16 ? {1'b0, a_lo_q[0] ^ bigend} : (a_lo_q ^ {2{bigend}});
				end
			end
			SZ_WORD: begin
				dmuxu = LANE_WORD;
				if (rd && !dsp16) begin
					dmuxd = {a_lo_q[1] ^ bigend, 1'b0};
				end
			end
			default: begin
				if (two_ph_q) begin
					if (state == ST_HI && !rd) begin
						// Upper half out on both halves
						dmuxd = SEL_HI_HALF;
					end else begin
						// Lower half out, or the 16-bit input moved to the half being latched
						dmuxu = LANE_UP;
					end
				end
			end
		endcase
	end

	// The master waits for busy to fall before the next request
	a_req_not_busy: assert property (
		@(posedge sys_clk) disable iff (rst)
		req |-> !busy
	) else $error("request issued while busy");

	// A waiting phase keeps its strobe, direction and address half until ack
	a_strobe_hold: assert property (
		@(posedge sys_clk) disable iff (rst)
		ext_strobe && !ext_ack |=> ext_strobe && $stable(seta1) && $stable(ext_we)
	) else $error("strobe phase changed before ack");

endmodule

// File: src/jbus_lanes.sv
// Byte-lane steering, split read latches, address latch and config flags, driven by bus_cycle_ctrl in jbus_top
module jbus_lanes (
	input  logic                        sys_clk,
	input  logic                        rst,
	input  logic [jbus_pkg::DATA_W-1:0] wdata,
	input  logic [jbus_pkg::DATA_W-1:0] ext_din,
	input  logic [jbus_pkg::ADDR_W-1:0] a,
	input  logic                        ad_load,
	input  logic                        seta1,
	input  logic [1:0]                  dinlatch,
	input  logic [1:0]                  dmuxu,
	input  logic [1:0]                  dmuxd,
	input  logic                        xdsrc,
	input  logic [1:0]                  cfg,
	input  logic                        cfgw,
	output logic [jbus_pkg::DATA_W-1:0] dout,
	output logic [jbus_pkg::DATA_W-1:0] rdata,
	output logic [jbus_pkg::ADDR_W-1:0] aout,
	output logic                        dsp16,
	output logic                        bigend
);
	import jbus_pkg::*;

	// Selected source, write data or bus input
	logic [DATA_W-1:0] d1;
	// Half picked by dmuxd[1]
	logic [15:0] hsel;
	// Byte picked by dmuxd[0]
	logic [7:0] bsel;
	// Steered word, upper half always passes
	logic [DATA_W-1:0] steer;
	// Formatted lanes, shared by the outbound and inbound paths
	logic [DATA_W-1:0] lanes;
	// Read data halves
	logic [DATA_W-1:0] rd_q;
	// Phase address
	logic [ADDR_W-1:0] ad_q;

	// Source select
	// xdsrc high on reads
	assign d1 = xdsrc ? ext_din : wdata;

	// Downward steering
	// SEL_HI_HALF on a write brings the upper half of a split long to bits 15..0
	assign hsel = dmuxd[1] ? d1[31:16] : d1[15:0];
	assign bsel = dmuxd[0] ? hsel[15:8] : hsel[7:0];
	assign steer = {d1[31:16], hsel[15:8], bsel};

	// Lane format
	// Writes copy low lanes upward, reads clear the lanes above the item
	always_comb begin
		case (dmuxu)
			LANE_PASS: begin
				lanes = steer;
			end
			LANE_UP: begin
				lanes = {steer[15:0], steer[15:0]};
			end
			LANE_WORD: begin
				lanes = {xdsrc ? 16'h0000 : steer[15:0], steer[15:0]};
			end
			LANE_BYTE: begin
				lanes = xdsrc ? {24'h000000, steer[7:0]} : {4{steer[7:0]}};
			end
		endcase
	end

	// Outbound data for ext_dout
	assign dout = lanes;

	// Split read latches
	// Each half loads only on its own enable, so a split long assembles over two phases
	always_ff @(posedge sys_clk) begin
		if (dinlatch[0]) begin
			rd_q[15:0] <= lanes[15:0];
		end
		if (dinlatch[1]) begin
			rd_q[31:16] <= lanes[31:16];
		end
	end

	// Already steered and zero-extended before capture
	assign rdata = rd_q;

	// Address latch
	// Loaded once per transfer, on the accepted request
	always_ff @(posedge sys_clk) begin
		if (ad_load) begin
			ad_q <= a;
		end
	end

	// Bit 1 forced for the lower half of a split long
	assign aout = ad_q | {{(ADDR_W-2){1'b0}}, seta1, 1'b0};

	// Configuration flags
	// cfgw already qualified by the top level
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			dsp16 <= 1'b0;
			bigend <= 1'b0;
		end else if (cfgw) begin
			dsp16 <= cfg[CFG_DSP16];
			bigend <= cfg[CFG_BIGEND];
		end
	end

	// Latch enables only come from an active phase, which the top keeps apart from cfgw
	a_no_latch_on_cfg: assert property (
		@(posedge sys_clk) disable iff (rst)
		!(cfgw && (dinlatch != 2'b00))
	) else $error("read latch enabled during a configuration write");

endmodule

// File: src/jbus_pkg.sv
// Shared widths, configuration bits, lane codes and enums for the external bus interface, imported by all RTL
package jbus_pkg;

	// Local and external address width
	localparam int ADDR_W = 24;

	// Local and external data width
	localparam int DATA_W = 32;

	// Bit positions inside the 2-bit configuration word
	localparam int CFG_DSP16 = 0;
	localparam int CFG_BIGEND = 1;

	// Lane format codes on dmuxu
	// Outbound data is replicated, inbound byte and word data is zero-filled
	// Straight through, all four lanes as they are
	localparam logic [1:0] LANE_PASS = 2'b00;
	// Low half mirrored into the upper half, in both directions
	localparam logic [1:0] LANE_UP = 2'b01;
	// Word in bits 15..0
	localparam logic [1:0] LANE_WORD = 2'b10;
	// Byte in bits 7..0
	localparam logic [1:0] LANE_BYTE = 2'b11;

	// Steering selects on dmuxd
	// Bit 1 picks the half, bit 0 picks the byte inside it
	localparam logic [1:0] SEL_LO_HALF = 2'b00;
	localparam logic [1:0] SEL_HI_HALF = 2'b10;

	// Transfer size requested by the local master
	typedef enum logic [1:0] {
		SZ_BYTE = 2'b00,
		SZ_WORD = 2'b01,
		SZ_LONG = 2'b10
	} xfer_size_e;

	// Bus sequencer states
	// ST_HI is the upper-half phase of a split long
	// ST_LO is the only phase or the lower-half phase
	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_HI = 2'b01,
		ST_LO = 2'b10,
		ST_DONE = 2'b11
	} cyc_state_e;

endpackage

// File: src/jbus_top.sv
// Top level of the external bus interface, joining the sequencer and the lane datapath to the pins
module jbus_top (
	input  logic                        sys_clk,
	input  logic                        rst,
	input  logic                        req,
	input  logic                        we,
	input  jbus_pkg::xfer_size_e        size,
	input  logic [jbus_pkg::ADDR_W-1:0] addr,
	input  logic [jbus_pkg::DATA_W-1:0] wdata,
	input  logic [1:0]                  cfg,
	input  logic                        cfg_wr,
	input  logic [jbus_pkg::DATA_W-1:0] ext_din,
	input  logic                        ext_ack,
	output logic                        busy,
	output logic                        done,
	output logic [jbus_pkg::DATA_W-1:0] rdata,
	output logic [jbus_pkg::ADDR_W-1:0] ext_addr,
	output logic [jbus_pkg::DATA_W-1:0] ext_dout,
	output logic                        ext_we,
	output logic                        ext_strobe,
	output logic                        dsp16,
	output logic                        bigend
);

	// Sequencer to datapath controls
	logic ad_load;
	logic seta1;
	logic xdsrc;
	logic [1:0] dinlatch;
	logic [1:0] dmuxu;
	logic [1:0] dmuxd;

	// Config writes only land between transfers
	logic cfgw;
	assign cfgw = cfg_wr && !busy;

	bus_cycle_ctrl u_ctrl (
		.sys_clk    (sys_clk),
		.rst        (rst),
		.req        (req),
		.we         (we),
		.size       (size),
		.addr_lo    (addr[1:0]),
		.dsp16      (dsp16),
		.bigend     (bigend),
		.ext_ack    (ext_ack),
		.busy       (busy),
		.done       (done),
		.ext_strobe (ext_strobe),
		.ext_we     (ext_we),
		.ad_load    (ad_load),
		.seta1      (seta1),
		.dinlatch   (dinlatch),
		.dmuxu      (dmuxu),
		.dmuxd      (dmuxd),
		.xdsrc      (xdsrc)
	);

	// Address and data lanes, config flags fed back to the sequencer
	jbus_lanes u_lanes (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.wdata    (wdata),
		.ext_din  (ext_din),
		.a        (addr),
		.ad_load  (ad_load),
		.seta1    (seta1),
		.dinlatch (dinlatch),
		.dmuxu    (dmuxu),
		.dmuxd    (dmuxd),
		.xdsrc    (xdsrc),
		.cfg      (cfg),
		.cfgw     (cfgw),
		.dout     (ext_dout),
		.rdata    (rdata),
		.aout     (ext_addr),
		.dsp16    (dsp16),
		.bigend   (bigend)
	);

endmodule

// File: test/jbus_ref.svh
// Reference model for the jbus testbench, included in tb_jbus: expected lanes, phase addresses, memory
`ifndef JBUS_REF_SVH
`define JBUS_REF_SVH

// Memory fill for addresses never written
// Every address bit reaches the word
function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
	return {a[7:0], a} ^ {a, a[23:16]} ^ 32'h5ac3_3ca5;
endfunction

// Only a long on the 16-bit bus is split
function automatic int phase_count(input xfer_size_e sz, input logic d16);
	return ((sz == SZ_LONG) && d16) ? 2 : 1;
endfunction

// Split long: bit 1 clear for the upper half, set for the lower half
function automatic logic [ADDR_W-1:0] phase_addr(
	input logic [ADDR_W-1:0] a,
	input xfer_size_e sz,
	input logic d16,
	input int idx
);
	logic [ADDR_W-1:0] res;
	res = a;
	if (phase_count(sz, d16) == 2) begin
		res[1] = (idx != 0);
	end
	return res;
endfunction

// Outbound lanes of one phase
function automatic logic [DATA_W-1:0] write_lanes(
	input xfer_size_e sz,
	input logic [DATA_W-1:0] d,
	input logic d16,
	input int idx
);
	logic [DATA_W-1:0] res;
	case (sz)
		SZ_BYTE: res = {4{d[7:0]}};
		SZ_WORD: res = {2{d[15:0]}};
		default: begin
			if (!d16) begin
				res = d;
			end else if (idx == 0) begin
				res = {2{d[31:16]}};
			end else begin
				res = {2{d[15:0]}};
			end
		end
	endcase
	return res;
endfunction

// Expected rdata from the data the bus returned
// din_last only matters for the second half of a split long
function automatic logic [DATA_W-1:0] read_result(
	input xfer_size_e sz,
	input logic [ADDR_W-1:0] a,
	input logic d16,
	input logic be,
	input logic [DATA_W-1:0] din_first,
	input logic [DATA_W-1:0] din_last
);
	logic [1:0] lane;
	logic upper;
	logic [DATA_W-1:0] res;
	res = '0;
	lane = be ? 2'd3 - a[1:0] : a[1:0];
	if (!d16) begin
		upper = be ? !a[1] : a[1];
		case (sz)
			SZ_BYTE: res[7:0] = din_first[8*lane +: 8];
			SZ_WORD: res[15:0] = upper ? din_first[31:16] : din_first[15:0];
			default: res = din_first;
		endcase
	end else begin
		// 16-bit bus, byte picked by address bit 0
		upper = be ? !a[0] : a[0];
		case (sz)
			SZ_BYTE: res[7:0] = upper ? din_first[15:8] : din_first[7:0];
			SZ_WORD: res[15:0] = din_first[15:0];
			default: res = {din_first[15:0], din_last[15:0]};
		endcase
	end
	return res;
endfunction

// External memory, answers one strobe phase
// Called on a falling edge with the strobe up, returns on the edge that drops the ack
task automatic serve_phase();
	int wait_cyc;
	logic [ADDR_W-1:0] held_addr;
	phase_t ph;
	wait_cyc = $unsigned($random(seed)) % 6;
	held_addr = ext_addr;
	// Address and strobe must hold while the ack is withheld
	repeat (wait_cyc) begin
		@(negedge sys_clk);
		check_addr("ext_addr", held_addr, ext_addr);
		check_flag("ext_strobe", 1'b1, ext_strobe);
	end
	ph.addr = ext_addr;
	ph.we = ext_we;
	ph.dout = ext_dout;
	if (ext_we) begin
		ph.din = '0;
		mem[ext_addr] = ext_dout;
	end else begin
		ph.din = mem.exists(ext_addr) ? mem[ext_addr] : fill_word(ext_addr);
	end
	phases.push_back(ph);
	ext_din = ph.din;
	ext_ack = 1'b1;
	@(negedge sys_clk);
	ext_ack = 1'b0;
	ext_din = '0;
endtask

`endif

// File: test/tb_jbus.sv
// Testbench for jbus_top: drives local transfers against a memory model and checks every phase and result
module tb_jbus;
	timeunit 1ns;
	timeprecision 100ps;
	import jbus_pkg::*;

	// Transfer counts of the four test groups
	localparam int N_XFER = 1 + 2 * (4 * 4 + 2) + 2 * (4 * 2 + 2) + 40;

	// One local request, with the config it ran under
	typedef struct packed {
		logic we;
		xfer_size_e size;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic d16;
		logic be;
	} xfer_t;

	// One strobe phase as seen by the memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic we;
		logic [DATA_W-1:0] dout;
		logic [DATA_W-1:0] din;
	} phase_t;

	logic sys_clk = 1'b0;
	logic rst;
	logic req;
	logic we;
	xfer_size_e size;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [1:0] cfg;
	logic cfg_wr;
	logic [DATA_W-1:0] ext_din;
	logic ext_ack;
	logic busy;
	logic done;
	logic [DATA_W-1:0] rdata;
	logic [ADDR_W-1:0] ext_addr;
	logic [DATA_W-1:0] ext_dout;
	logic ext_we;
	logic ext_strobe;
	logic dsp16;
	logic bigend;

	integer seed = 32'h8f9df68d;
	// Config as the testbench wrote it
	logic cfg_d16;
	logic cfg_be;
	int done_count;
	xfer_t xfers[$];
	phase_t phases[$];
	logic [DATA_W-1:0] mem[logic [ADDR_W-1:0]];

	`include "jbus_ref.svh"

	jbus_top u_dut (
		.sys_clk    (sys_clk),
		.rst        (rst),
		.req        (req),
		.we         (we),
		.size       (size),
		.addr       (addr),
		.wdata      (wdata),
		.cfg        (cfg),
		.cfg_wr     (cfg_wr),
		.ext_din    (ext_din),
		.ext_ack    (ext_ack),
		.busy       (busy),
		.done       (done),
		.rdata      (rdata),
		.ext_addr   (ext_addr),
		.ext_dout   (ext_dout),
		.ext_we     (ext_we),
		.ext_strobe (ext_strobe),
		.dsp16      (dsp16),
		.bigend     (bigend)
	);

	// 40 ns clock
	always #20 sys_clk = ~sys_clk;

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
		input logic [ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// Config write from a falling edge, flags checked one cycle later
	task automatic write_cfg(input logic d16, input logic be);
		cfg[CFG_DSP16] = d16;
		cfg[CFG_BIGEND] = be;
		cfg_wr = 1'b1;
		@(negedge sys_clk);
		cfg_wr = 1'b0;
		cfg_d16 = d16;
		cfg_be = be;
		check_flag("dsp16", cfg_d16, dsp16);
		check_flag("bigend", cfg_be, bigend);
	endtask

	// Issue one request and return on the falling edge where done is high
	// The next request can then start at once
	task automatic run_xfer(input logic w, input xfer_size_e sz, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d);
		xfer_t x;
		x.we = w;
		x.size = sz;
		x.addr = a;
		x.wdata = d;
		x.d16 = cfg_d16;
		x.be = cfg_be;
		xfers.push_back(x);
		req = 1'b1;
		we = w;
		size = sz;
		addr = a;
		wdata = d;
		@(negedge sys_clk);
		req = 1'b0;
		// Busy follows the request by one cycle
		check_flag("busy", 1'b1, busy);
		while (!done) begin
			@(negedge sys_clk);
		end
		// Busy falls together with done
		check_flag("busy", 1'b0, busy);
	endtask

	// Compare phases and read data of the finished transfer
	task automatic check_xfer();
		xfer_t x;
		int n;
		if (xfers.size() == 0) begin
			$display("done pulse seen with no request outstanding");
			abort_run();
		end else begin
			x = xfers.pop_front();
			n = phase_count(x.size, x.d16);
			if (phases.size() != n) begin
				$display("transfer at %h ran %0d bus phases instead of %0d", x.addr,
					phases.size(), n);
				abort_run();
			end else begin
				for (int i = 0; i < n; i++) begin
					check_addr("ext_addr", phase_addr(x.addr, x.size, x.d16, i), phases[i].addr);
					check_flag("ext_we", x.we, phases[i].we);
					if (x.we) begin
						check_data("ext_dout", write_lanes(x.size, x.wdata, x.d16, i),
							phases[i].dout);
					end
				end
				if (!x.we) begin
					check_data("rdata", read_result(x.size, x.addr, x.d16, x.be,
						phases[0].din, phases[n-1].din), rdata);
				end
				phases.delete();
				done_count++;
			end
		end
	endtask

	// Memory model
	always @(negedge sys_clk) begin
		if (ext_strobe) begin
			serve_phase();
		end
	end

	// Checker
	always @(negedge sys_clk) begin
		if (!rst && done) begin
			check_xfer();
		end
	end

	// Watchdog
	initial begin
		repeat (N_XFER * 20 + 100) @(posedge sys_clk);
		$display("Timeout: transfers stalled, sequencer in %s", u_dut.u_ctrl.state.name());
		abort_run();
	end

	initial begin
		logic [31:0] r;
		logic [ADDR_W-1:0] a;
		xfer_size_e sz;
		rst = 1'b1;
		req = 1'b0;
		we = 1'b0;
		size = SZ_BYTE;
		addr = '0;
		wdata = '0;
		cfg = 2'b00;
		cfg_wr = 1'b0;
		ext_din = '0;
		ext_ack = 1'b0;
		cfg_d16 = 1'b0;
		cfg_be = 1'b0;
		done_count = 0;
		repeat (2) @(negedge sys_clk);
		rst = 1'b0;
		@(negedge sys_clk);

		// Reset state and config flags
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("ext_strobe", 1'b0, ext_strobe);
		check_flag("dsp16", 1'b0, dsp16);
		check_flag("bigend", 1'b0, bigend);
		write_cfg(1'b1, 1'b1);
		write_cfg(1'b0, 1'b0);
		// Config write while busy is dropped
		fork
			run_xfer(1'b1, SZ_BYTE, 24'h001230, 32'h0000_00a5);
			begin
				@(negedge sys_clk);
				cfg = 2'b11;
				cfg_wr = 1'b1;
				@(negedge sys_clk);
				cfg_wr = 1'b0;
			end
		join
		check_flag("dsp16", cfg_d16, dsp16);
		check_flag("bigend", cfg_be, bigend);

		// 32-bit bus, both byte orders
		for (int be = 0; be < 2; be++) begin
			write_cfg(1'b0, be[0]);
			for (int lo = 0; lo < 4; lo++) begin
				a = 24'h0a4c10 + 24'(lo);
				r = $random(seed);
				run_xfer(1'b1, SZ_BYTE, a, r);
				run_xfer(1'b0, SZ_BYTE, a + 24'h000100, '0);
				run_xfer(1'b1, SZ_WORD, a, r);
				run_xfer(1'b0, SZ_WORD, a + 24'h000200, '0);
			end
			r = $random(seed);
			run_xfer(1'b1, SZ_LONG, 24'h0a4c20, r);
			run_xfer(1'b0, SZ_LONG, 24'h0a4d20, '0);
		end

		// 16-bit bus, split longs
		for (int be = 0; be < 2; be++) begin
			write_cfg(1'b1, be[0]);
			for (int lo = 0; lo < 4; lo++) begin
				run_xfer(1'b0, SZ_BYTE, 24'h3b7040 + 24'(lo), '0);
				run_xfer(1'b0, SZ_WORD, 24'h3b7140 + 24'(lo), '0);
			end
			r = $random(seed);
			run_xfer(1'b1, SZ_LONG, 24'h3b7280, r);
			run_xfer(1'b0, SZ_LONG, 24'h3b7280, '0);
		end

		// Random back-to-back traffic in blocks of ten
		for (int blk = 0; blk < 4; blk++) begin
			r = $random(seed);
			write_cfg(r[0], r[1]);
			for (int i = 0; i < 10; i++) begin
				r = $random(seed);
				sz = xfer_size_e'(r[7:0] % 3);
				a = 24'h5a0100 + 24'(r[13:8]);
				if (sz == SZ_LONG) begin
					a[1:0] = 2'b00;
				end
				run_xfer(r[4], sz, a, $random(seed));
			end
		end

		// Let the checker see the last done
		@(negedge sys_clk);
		if (done_count != N_XFER || xfers.size() != 0) begin
			$display("saw %0d done pulses for %0d transfers", done_count, N_XFER);
			abort_run();
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule
